/* design/line_store_pkg.sv */
// Shared widths for the line store behind the APB port.
// The top level takes its parameter defaults from here; the derived field
// sizes describe how a byte address splits into byte, offset and index.

package line_store_pkg;

    // APB data word
    localparam int DATA_WIDTH = 32;

    // one SRAM line, 16 words at the default word size
    localparam int LINE_WIDTH = 512;

    // line index, 64 lines
    localparam int INDEX_WIDTH = 6;

    // APB byte address
    localparam int ADDR_WIDTH = 16;

    // word offset inside a line
    localparam int OFFSET_WIDTH = $clog2(LINE_WIDTH / DATA_WIDTH);

    // byte within a word
    localparam int BYTE_SEL_WIDTH = $clog2(DATA_WIDTH / 8);

    // bytes covered by the index, offset and byte fields together
    localparam int MEM_BYTES = 2 ** (INDEX_WIDTH + OFFSET_WIDTH + BYTE_SEL_WIDTH);

    // strobe bits per word
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

endpackage

/* design/line_sram.sv */
// Single-port line-wide SRAM model.
// The read address is registered, so data follows one cycle after addr.
// A write on the same edge is seen by the read of that address (write-first).

module line_sram #(
    parameter int LINE_WIDTH  = line_store_pkg::LINE_WIDTH,
    parameter int INDEX_WIDTH = line_store_pkg::INDEX_WIDTH
) (
    input  logic                   clk,
    input  logic [INDEX_WIDTH-1:0] addr,
    input  logic                   we,
    input  logic [INDEX_WIDTH-1:0] waddr,
    input  logic [LINE_WIDTH-1:0]  wdata,
    output logic [LINE_WIDTH-1:0]  rdata
);

    localparam int DEPTH = 2 ** INDEX_WIDTH;

    logic [LINE_WIDTH-1:0]  mem [DEPTH];
    logic [INDEX_WIDTH-1:0] addr_q;

    // storage array, no reset on contents
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read address register
    always_ff @(posedge clk) begin
        addr_q <= addr;
    end

    // array is read after the write has landed
    assign rdata = mem[addr_q];

    // a write must target a known line
    waddr_known_on_write: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("line_sram write with unknown waddr");

endmodule

/* design/word_select.sv */
// Read data stage: picks one word out of a fetched line.
// Word 0 sits in the lowest bits of the line. Purely combinational.

module word_select #(
    parameter int DATA_WIDTH = line_store_pkg::DATA_WIDTH,
    parameter int LINE_WIDTH = line_store_pkg::LINE_WIDTH
) (
    input  logic [$clog2(LINE_WIDTH / DATA_WIDTH)-1:0] offset,
    input  logic [LINE_WIDTH-1:0]                      line,
    output logic [DATA_WIDTH-1:0]                      word
);

    localparam int WORDS        = LINE_WIDTH / DATA_WIDTH;
    localparam int OFFSET_WIDTH = $clog2(WORDS);

    // one comparator per word slot
    always_comb begin
        word = '0;
        for (int i = 0; i < WORDS; i++) begin
            if (offset == OFFSET_WIDTH'(i)) begin
                word = line[i*DATA_WIDTH +: DATA_WIDTH];
            end
        end
    end

endmodule

/* design/line_merge.sv */
// Write data stage: merges a byte-strobed word into the old line.
// Strobes are spread into a line-wide byte mask at the word offset;
// masked bytes come from the write word, the rest from old_line.

module line_merge #(
    parameter int DATA_WIDTH = line_store_pkg::DATA_WIDTH,
    parameter int LINE_WIDTH = line_store_pkg::LINE_WIDTH
) (
    input  logic [$clog2(LINE_WIDTH / DATA_WIDTH)-1:0] offset,
    input  logic [DATA_WIDTH/8-1:0]                    strb,
    input  logic [DATA_WIDTH-1:0]                      wdata,
    input  logic [LINE_WIDTH-1:0]                      old_line,
    output logic [LINE_WIDTH-1:0]                      merged_line
);

    localparam int WORDS        = LINE_WIDTH / DATA_WIDTH;
    localparam int OFFSET_WIDTH = $clog2(WORDS);
    localparam int WORD_BYTES   = DATA_WIDTH / 8;
    localparam int LINE_BYTES   = LINE_WIDTH / 8;

    logic [LINE_BYTES-1:0] byte_mask;
    logic [LINE_WIDTH-1:0] wdata_line;

    // place strobes and write word at the addressed slot
    always_comb begin
        byte_mask  = '0;
        wdata_line = '0;
        for (int w = 0; w < WORDS; w++) begin
            if (offset == OFFSET_WIDTH'(w)) begin
                byte_mask[w*WORD_BYTES +: WORD_BYTES] = strb;
                wdata_line[w*DATA_WIDTH +: DATA_WIDTH] = wdata;
            end
        end
    end

    // bytewise merge
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            if (byte_mask[b]) begin
                merged_line[b*8 +: 8] = wdata_line[b*8 +: 8];
            end else begin
                merged_line[b*8 +: 8] = old_line[b*8 +: 8];
            end
        end
    end

endmodule

/* design/apb_access_ctrl.sv */
// APB slave sequencer for the line store.
// Decodes paddr at setup, fetches the line, writes the merged line back for
// writes and answers in the second access cycle, three cycles per transfer.

module apb_access_ctrl #(
    parameter int DATA_WIDTH  = line_store_pkg::DATA_WIDTH,
    parameter int INDEX_WIDTH = line_store_pkg::INDEX_WIDTH,
    parameter int LINE_WIDTH  = line_store_pkg::LINE_WIDTH
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       psel,
    input  logic                                       penable,
    input  logic                                       pwrite,
    input  logic [line_store_pkg::ADDR_WIDTH-1:0]      paddr,
    input  logic [DATA_WIDTH-1:0]                      pwdata,
    input  logic [DATA_WIDTH/8-1:0]                    pstrb,
    output logic [DATA_WIDTH-1:0]                      prdata,
    output logic                                       pready,
    output logic                                       pslverr,
    output logic [INDEX_WIDTH-1:0]                     sram_addr,
    output logic                                       sram_we,
    output logic [INDEX_WIDTH-1:0]                     sram_waddr,
    output logic [$clog2(LINE_WIDTH / DATA_WIDTH)-1:0] word_offset,
    output logic [DATA_WIDTH-1:0]                      wdata,
    output logic [DATA_WIDTH/8-1:0]                    wstrb,
    input  logic [DATA_WIDTH-1:0]                      sel_word
);

    localparam int OFFSET_WIDTH   = $clog2(LINE_WIDTH / DATA_WIDTH);
    localparam int BYTE_SEL_WIDTH = $clog2(DATA_WIDTH / 8);
    localparam int LOW_BITS       = BYTE_SEL_WIDTH + OFFSET_WIDTH + INDEX_WIDTH;

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_FETCH   = 2'd1;
    localparam logic [1:0] ST_RESPOND = 2'd2;

    logic [1:0]             state;
    logic                   setup;
    logic                   addr_err;
    logic [INDEX_WIDTH-1:0] index_in;
    logic [INDEX_WIDTH-1:0] index_q;
    logic                   write_q;
    logic                   err_q;

    // only accept a setup once the previous transfer has finished
    assign setup = (state == ST_IDLE) && psel && !penable;

    // byte bits, then offset, then index from the bottom of paddr
    assign index_in = paddr[BYTE_SEL_WIDTH+OFFSET_WIDTH +: INDEX_WIDTH];

    // misaligned, or beyond the last line
    assign addr_err = (paddr[BYTE_SEL_WIDTH-1:0] != '0) || ((paddr >> LOW_BITS) != '0);

    // SRAM sees the live index during setup, the held one afterwards
    assign sram_addr  = (state == ST_IDLE) ? index_in : index_q;
    assign sram_waddr = index_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ST_IDLE;
            write_q <= 1'b0;
            err_q   <= 1'b0;
            sram_we <= 1'b0;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            prdata  <= '0;
        end else begin
            sram_we <= 1'b0;
            pready  <= 1'b0;
            pslverr <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (setup) begin
                        write_q <= pwrite;
                        err_q   <= addr_err;
                        // write-back happens at the end of the fetch cycle
                        sram_we <= pwrite && !addr_err;
                        state   <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    // line is valid now, so the selected word is too
                    prdata  <= (!write_q && !err_q) ? sel_word : '0;
                    pready  <= 1'b1;
                    pslverr <= err_q;
                    state   <= ST_RESPOND;
                end
                ST_RESPOND: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // captured transfer fields
    always_ff @(posedge clk) begin
        if (setup) begin
            index_q     <= index_in;
            word_offset <= paddr[BYTE_SEL_WIDTH +: OFFSET_WIDTH];
            wdata       <= pwdata;
            wstrb       <= pstrb;
        end
    end

    // response only while the master holds an access phase
    pready_in_access: assert property (
        @(posedge clk) disable iff (!rst_n) pready |-> (psel && penable)
    ) else $error("pready outside APB access phase");

    // array written only for a held paddr that decodes without error
    no_write_on_error: assert property (
        @(posedge clk) disable iff (!rst_n) sram_we |-> !addr_err
    ) else $error("SRAM write during error transfer");

endmodule

/* design/line_store_top.sv */
// Line-organized scratchpad behind an APB slave port.
// Control stage drives the SRAM; word_select and line_merge form the
// read and write data paths around the line read data.

module line_store_top #(
    parameter int DATA_WIDTH  = line_store_pkg::DATA_WIDTH,
    parameter int LINE_WIDTH  = line_store_pkg::LINE_WIDTH,
    parameter int INDEX_WIDTH = line_store_pkg::INDEX_WIDTH
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [line_store_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic [DATA_WIDTH-1:0]                 pwdata,
    input  logic [DATA_WIDTH/8-1:0]               pstrb,
    output logic [DATA_WIDTH-1:0]                 prdata,
    output logic                                  pready,
    output logic                                  pslverr
);

    localparam int OFFSET_WIDTH = $clog2(LINE_WIDTH / DATA_WIDTH);

    logic [INDEX_WIDTH-1:0]  sram_addr;
    logic                    sram_we;
    logic [INDEX_WIDTH-1:0]  sram_waddr;
    logic [OFFSET_WIDTH-1:0] word_offset;
    logic [DATA_WIDTH-1:0]   wdata;
    logic [DATA_WIDTH/8-1:0] wstrb;
    logic [DATA_WIDTH-1:0]   sel_word;
    logic [LINE_WIDTH-1:0]   line_rdata;
    logic [LINE_WIDTH-1:0]   merged_line;

    apb_access_ctrl #(
        .DATA_WIDTH  (DATA_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH),
        .LINE_WIDTH  (LINE_WIDTH)
    ) ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .sram_addr   (sram_addr),
        .sram_we     (sram_we),
        .sram_waddr  (sram_waddr),
        .word_offset (word_offset),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .sel_word    (sel_word)
    );

    line_sram #(
        .LINE_WIDTH  (LINE_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) sram_i (
        .clk   (clk),
        .addr  (sram_addr),
        .we    (sram_we),
        .waddr (sram_waddr),
        .wdata (merged_line),
        .rdata (line_rdata)
    );

    word_select #(
        .DATA_WIDTH (DATA_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    ) rd_sel_i (
        .offset (word_offset),
        .line   (line_rdata),
        .word   (sel_word)
    );

    line_merge #(
        .DATA_WIDTH (DATA_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    ) wr_merge_i (
        .offset      (word_offset),
        .strb        (wstrb),
        .wdata       (wdata),
        .old_line    (line_rdata),
        .merged_line (merged_line)
    );

endmodule

/* dv/line_store_tb.sv */
// Testbench for the APB line store. Runs a directed table, fills a region of
// lines, then a seeded random tail checked against a shadow array of lines.
// Run through flist.f with line_store_tb as the top module.

module line_store_tb;

    localparam int DATA_WIDTH  = line_store_pkg::DATA_WIDTH;
    localparam int LINE_WIDTH  = line_store_pkg::LINE_WIDTH;
    localparam int INDEX_WIDTH = line_store_pkg::INDEX_WIDTH;
    localparam int ADDR_WIDTH  = line_store_pkg::ADDR_WIDTH;
    localparam int LINES       = 2 ** INDEX_WIDTH;
    localparam int LINE_BYTES  = LINE_WIDTH / 8;
    localparam int MEM_BYTES   = LINES * LINE_BYTES;
    localparam int TIMEOUT     = 20;
    localparam int FILL_LINES  = 8;
    localparam int RANDOM_OPS  = 40;

    logic                    clk;
    logic                    rst_n;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [ADDR_WIDTH-1:0]   paddr;
    logic [DATA_WIDTH-1:0]   pwdata;
    logic [DATA_WIDTH/8-1:0] pstrb;
    logic [DATA_WIDTH-1:0]   prdata;
    logic                    pready;
    logic                    pslverr;

    int errors;

    // expected contents of every line
    logic [LINE_WIDTH-1:0] shadow [LINES];

    // directed stimulus table, one entry per index
    string                   tbl_name  [$];
    bit                      tbl_write [$];
    logic [ADDR_WIDTH-1:0]   tbl_addr  [$];
    logic [DATA_WIDTH/8-1:0] tbl_strb  [$];
    logic [DATA_WIDTH-1:0]   tbl_wdata [$];
    logic [DATA_WIDTH-1:0]   tbl_rdata [$];
    bit                      tbl_err   [$];

    line_store_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .LINE_WIDTH  (LINE_WIDTH),
        .INDEX_WIDTH (INDEX_WIDTH)
    ) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_entry(input string name, input bit wr, input logic [15:0] addr,
                             input logic [3:0] strb, input logic [31:0] wdata,
                             input logic [31:0] exp_rdata, input bit exp_err);
        tbl_name.push_back(name);
        tbl_write.push_back(wr);
        tbl_addr.push_back(addr);
        tbl_strb.push_back(strb);
        tbl_wdata.push_back(wdata);
        tbl_rdata.push_back(exp_rdata);
        tbl_err.push_back(exp_err);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // misaligned, or past the last byte of the array
    function automatic bit addr_is_bad(input logic [15:0] addr);
        return (addr[1:0] != 2'b00) || (int'(addr) >= MEM_BYTES);
    endfunction

    function automatic void shadow_write(input logic [15:0] addr, input logic [3:0] strb,
                                         input logic [31:0] data);
        int line_idx;
        int byte_pos;
        line_idx = int'(addr) / LINE_BYTES;
        byte_pos = int'(addr) % LINE_BYTES;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                shadow[line_idx][(byte_pos + b) * 8 +: 8] = data[b * 8 +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] shadow_read(input logic [15:0] addr);
        int line_idx;
        int byte_pos;
        line_idx = int'(addr) / LINE_BYTES;
        byte_pos = int'(addr) % LINE_BYTES;
        return shadow[line_idx][byte_pos * 8 +: DATA_WIDTH];
    endfunction

    // one APB transfer; cycles counts edges from the setup edge to completion
    task automatic apb_transfer(input bit wr, input logic [15:0] addr, input logic [3:0] strb,
                                input logic [31:0] data, output logic [31:0] rdata,
                                output logic err, output int cycles, output bit done);
        rdata = '0;
        err   = 1'b0;
        done  = 1'b0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        cycles = 1;
        while (!done && cycles < TIMEOUT) begin
            @(negedge clk);
            if (pready) begin
                rdata = prdata;
                err   = pslverr;
                done  = 1'b1;
            end
            @(posedge clk);
            cycles++;
        end
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic run_one(input string name, input bit wr, input logic [15:0] addr,
                           input logic [3:0] strb, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input bit exp_err);
        logic [31:0] rdata;
        logic        err;
        int          cycles;
        bit          done;
        apb_transfer(wr, addr, strb, wdata, rdata, err, cycles, done);
        assert (done) else begin
            $display("pready never came for transfer %s", name);
            errors++;
        end
        if (done) begin
            check_value({name, "_cycles"}, 32'd3, 32'(cycles));
            check_value({name, "_pslverr"}, 32'(exp_err), 32'(err));
            if (!wr && !exp_err) begin
                check_value(name, exp_rdata, rdata);
            end
        end
        if (wr && !exp_err) begin
            shadow_write(addr, strb, wdata);
        end
    endtask

    task automatic build_table();
        add_entry("full_write_w0",   1'b1, 16'h0000, 4'hf, 32'h11223344, 32'h0, 1'b0);
        add_entry("full_read_w0",    1'b0, 16'h0000, 4'h0, 32'h0, 32'h11223344, 1'b0);
        add_entry("nbr_write_w1",    1'b1, 16'h0004, 4'hf, 32'ha5a5a5a5, 32'h0, 1'b0);
        add_entry("nbr_write_w2",    1'b1, 16'h0008, 4'hf, 32'h5a5a5a5a, 32'h0, 1'b0);
        add_entry("part_write_b0",   1'b1, 16'h0004, 4'h1, 32'h000000ee, 32'h0, 1'b0);
        add_entry("part_read_b0",    1'b0, 16'h0004, 4'h0, 32'h0, 32'ha5a5a5ee, 1'b0);
        add_entry("part_write_b23",  1'b1, 16'h0004, 4'hc, 32'h7788ffff, 32'h0, 1'b0);
        add_entry("part_read_b23",   1'b0, 16'h0004, 4'h0, 32'h0, 32'h7788a5ee, 1'b0);
        add_entry("nbr_read_w0",     1'b0, 16'h0000, 4'h0, 32'h0, 32'h11223344, 1'b0);
        add_entry("nbr_read_w2",     1'b0, 16'h0008, 4'h0, 32'h0, 32'h5a5a5a5a, 1'b0);
        add_entry("line5_write_w15", 1'b1, 16'h017c, 4'hf, 32'hcafef00d, 32'h0, 1'b0);
        add_entry("line63_write_w7", 1'b1, 16'h0fdc, 4'hf, 32'h0badbeef, 32'h0, 1'b0);
        add_entry("line5_read_w15",  1'b0, 16'h017c, 4'h0, 32'h0, 32'hcafef00d, 1'b0);
        add_entry("line63_read_w7",  1'b0, 16'h0fdc, 4'h0, 32'h0, 32'h0badbeef, 1'b0);
        add_entry("line0_read_w0",   1'b0, 16'h0000, 4'h0, 32'h0, 32'h11223344, 1'b0);
        add_entry("misalign_write",  1'b1, 16'h0002, 4'hf, 32'hdeaddead, 32'h0, 1'b1);
        add_entry("misalign_alias",  1'b0, 16'h0000, 4'h0, 32'h0, 32'h11223344, 1'b0);
        add_entry("range_write",     1'b1, 16'h1004, 4'hf, 32'hdeaddead, 32'h0, 1'b1);
        add_entry("range_alias",     1'b0, 16'h0004, 4'h0, 32'h0, 32'h7788a5ee, 1'b0);
        add_entry("range_read",      1'b0, 16'h8008, 4'h0, 32'h0, 32'h0, 1'b1);
        add_entry("misalign_read",   1'b0, 16'h0179, 4'h0, 32'h0, 32'h0, 1'b1);
        add_entry("final_read_w2",   1'b0, 16'h0008, 4'h0, 32'h0, 32'h5a5a5a5a, 1'b0);
    endtask

    initial begin
        logic [15:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
        bit          wr;
        bit          bad;
        int          kind;
        errors = 0;
        void'($urandom(32'h72f6));
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset_pready", 32'h0, 32'(pready));
        check_value("reset_pslverr", 32'h0, 32'(pslverr));
        check_value("reset_prdata", 32'h0, prdata);

        build_table();
        for (int i = 0; i < tbl_name.size(); i++) begin
            run_one(tbl_name[i], tbl_write[i], tbl_addr[i], tbl_strb[i], tbl_wdata[i],
                    tbl_rdata[i], tbl_err[i]);
        end

        // known contents for the random region, pattern built from the address
        for (int a = 0; a < FILL_LINES * LINE_BYTES; a += 4) begin
            run_one("fill", 1'b1, 16'(a), 4'hf, {~16'(a), 16'(a)}, 32'h0, 1'b0);
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            wr   = 1'($urandom_range(1, 0));
            addr = 16'($urandom_range(FILL_LINES * LINE_BYTES / 4 - 1, 0) * 4);
            kind = int'($urandom_range(7, 0));
            if (kind == 0) begin
                addr[0] = 1'b1;
            end else if (kind == 1) begin
                addr[14] = 1'b1;
            end
            strb = 4'($urandom_range(15, 0));
            data = $urandom();
            bad  = addr_is_bad(addr);
            run_one($sformatf("rand_%0d", n), wr, addr, strb, data,
                    bad ? 32'h0 : shadow_read(addr), bad);
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
design/line_store_pkg.sv
design/line_sram.sv
design/word_select.sv
design/line_merge.sv
design/apb_access_ctrl.sv
design/line_store_top.sv
dv/line_store_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the line store testbench with Verilator.
# The result is taken from the simulation log, not from the exit status.

set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --assert --top-module line_store_tb -f flist.f -o line_store_sim

# keep going on a nonzero exit so the log search decides
./obj_dir/line_store_sim > "$LOG" 2>&1 || true

cat "$LOG"

if grep -q "^TB PASSED$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
